//--- build.f
verilog/nes_timing_pkg.sv
verilog/nes_bus_pkg.sv
verilog/clk_en_if.sv
verilog/dma_bus_if.sv
verilog/clock_enables.sv
verilog/dma_controller.sv
verilog/cpu_bus_decode.sv
verilog/memory_multiplex.sv
verilog/nes_bus_top.sv
dv/tb_nes_bus.sv

//--- dv/tb_nes_bus.sv
// Testbench for the bus and DMA subsystem
// Applies a table of CPU, DMC and CHR operations to nes_bus_top and checks
// sprite DMA ordering, DMC fetches, PPU priority on the shared memory and
// open-bus reads against a simple memory model
`timescale 1ns/10ps

module tb_nes_bus import nes_bus_pkg::*; ();

	logic clk;
	logic reset;
	logic cpu_rnw;
	logic dmc_req;
	logic chr_read;
	logic chr_write;
	cpu_addr_t cpu_addr;
	cpu_addr_t dmc_addr;
	data_t cpu_dout;
	data_t chr_din;
	data_t memory_din_cpu;
	mem_addr_t chr_addr;
	logic cpu_ce;
	logic ppu_ce;
	logic pause_cpu;
	logic dmc_ack;
	logic bus_write;
	logic ppu_write;
	logic memory_read_cpu;
	logic memory_read_ppu;
	logic memory_write;
	cpu_addr_t bus_addr;
	data_t bus_dout;
	data_t cpu_din;
	data_t memory_dout;
	mem_addr_t memory_addr;

	typedef enum logic [1:0] {OP_CPU_READ, OP_CPU_WRITE, OP_DMC_REQ, OP_CHR_READ} op_e;

	// Stimulus table, one row per test
	op_e tab_op [6];
	cpu_addr_t tab_addr [6];
	data_t tab_data [6];
	int tab_exp [6];      // Expected cpu_din, ack count or pair count
	int tab_dmc_at [6];   // CPU cycles into a sprite DMA before a DMC request, 0 for none
	string tab_name [6];

	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	int pair_count = 0;   // OAM writes seen in the current sprite DMA
	int last_read = -1;   // Index of the last sprite read seen
	int ack_count = 0;
	logic watch = 1'b0;   // Sprite DMA monitor armed
	data_t watch_page;
	data_t cycle_din;     // cpu_din at the end of the last CPU cycle
	integer seed = 92302;

	nes_bus_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Memory returns low address byte ^ $5A, one clk after a CPU read strobe
	initial begin
		memory_din_cpu = 8'h00;
		forever begin
			@(negedge clk);
			if (memory_read_cpu) begin
				@(posedge clk);
				#10 memory_din_cpu = memory_addr[7:0] ^ 8'h5A;
			end
		end
	end

	function automatic data_t model_data(input cpu_addr_t addr);
		return addr[7:0] ^ 8'h5A;
	endfunction

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what,
				actual, expected);
			error_count++;
		end
	endtask

	// One sample per CPU cycle, on the clk that carries cpu_ce
	always @(negedge clk) begin
		if (!reset && cpu_ce) begin
			if (dmc_ack) begin
				ack_count++;
				check_value("dmc fetch address", bus_addr, dmc_addr);
				check_value("dmc fetch is a read", bus_write, 0);
			end else if (watch && bus_write && bus_addr == 16'h2004) begin
				check_value("oam write strobe", ppu_write, 1);
				check_value("oam write follows its read", last_read, pair_count);
				check_value("oam write data", bus_dout,
					model_data({watch_page, pair_count[7:0]}));
				check_value("memory data out", memory_dout,
					model_data({watch_page, pair_count[7:0]}));
				pair_count++;
			end else if (watch && !bus_write && bus_addr[15:8] == watch_page) begin
				check_value("sprite read order", bus_addr[7:0], pair_count[7:0]);
				last_read = pair_count;
			end
		end
	end

	// Runs to the next cpu_ce and stops 10 ns into the following CPU cycle
	task automatic finish_cpu_cycle();
		@(negedge clk);
		while (!cpu_ce) @(negedge clk);
		cycle_din = cpu_din;
		@(posedge clk);
		#10;
	endtask

	task automatic drive_cpu(input logic rnw, input cpu_addr_t addr, input data_t dout);
		cpu_rnw = rnw;
		cpu_addr = addr;
		cpu_dout = dout;
	endtask

	task automatic measure_period(input logic use_cpu, input int expected);
		int clocks;
		clocks = 0;
		@(negedge clk);
		while (!(use_cpu ? cpu_ce : ppu_ce)) @(negedge clk);
		do begin
			@(negedge clk);
			clocks++;
		end while (!(use_cpu ? cpu_ce : ppu_ce));
		check_value(use_cpu ? "cpu_ce period" : "ppu_ce period", clocks, expected);
	endtask

	// Request held until the ack shows up, then dropped
	task automatic dmc_request();
		int rnd;
		rnd = $random(seed);
		dmc_addr = {1'b1, rnd[14:0]}; // Upper PRG range
		dmc_req = 1'b1;
		@(negedge clk);
		check_value("pause_cpu while dmc_req pending", pause_cpu, 1);
		while (!dmc_ack) @(negedge clk);
		@(posedge clk);
		#10 dmc_req = 1'b0;
	endtask

	task automatic sprite_dma(input cpu_addr_t addr, input data_t page, input int dmc_at,
			input int expected);
		pair_count = 0;
		last_read = -1;
		watch_page = page;
		watch = 1'b1;
		fork
			begin
				drive_cpu(1'b0, addr, page); // Page write starts the transfer
				finish_cpu_cycle();
				drive_cpu(1'b1, 16'h4050, 8'h00);
				do
					finish_cpu_cycle();
				while (pause_cpu); // End of DMA is pause_cpu falling
			end
			begin
				if (dmc_at > 0) begin
					repeat (dmc_at) finish_cpu_cycle();
					dmc_request();
				end
			end
		join
		watch = 1'b0;
		check_value("sprite read/write pairs", pair_count, expected);
		check_value("dmc fetches during sprite dma", ack_count, (dmc_at > 0) ? 1 : 0);
	endtask

	task automatic dmc_fetch(input int expected);
		dmc_request();
		repeat (3) finish_cpu_cycle();
		check_value("dmc acks", ack_count, expected);
		check_value("pause_cpu after dmc fetch", pause_cpu, 0);
		check_value("dmc_ack after dmc fetch", dmc_ack, 0);
	endtask

	// PRG read while the PPU holds the memory
	task automatic chr_then_cpu_read(input cpu_addr_t addr, input int expected);
		drive_cpu(1'b1, addr, 8'h00);
		chr_addr = 22'h2A5C3;
		chr_read = 1'b1;
		@(negedge clk);
		check_value("memory_addr during chr read", memory_addr, 22'h2A5C3);
		check_value("memory_read_ppu during chr read", memory_read_ppu, 1);
		check_value("memory_read_cpu during chr read", memory_read_cpu, 0);
		repeat (4) @(posedge clk); // Past the PRG window and its ppu_ce
		#10 chr_read = 1'b0;
		@(negedge clk);
		check_value("memory_read_cpu after chr read", memory_read_cpu, 1);
		check_value("memory_addr of held prg read", memory_addr, {6'd0, addr});
		finish_cpu_cycle();
		check_value("cpu_din of held prg read", cycle_din, expected);
		drive_cpu(1'b1, 16'h4050, 8'h00);
	endtask

	task automatic cpu_read(input cpu_addr_t addr, input int expected);
		drive_cpu(1'b1, addr, 8'h00);
		finish_cpu_cycle();
		check_value("cpu_din", cycle_din, expected);
		drive_cpu(1'b1, 16'h4050, 8'h00);
	endtask

	task automatic set_row(input int idx, input op_e op, input cpu_addr_t addr,
			input data_t data, input int expected, input int dmc_at, input string name);
		tab_op[idx] = op;
		tab_addr[idx] = addr;
		tab_data[idx] = data;
		tab_exp[idx] = expected;
		tab_dmc_at[idx] = dmc_at;
		tab_name[idx] = name;
	endtask

	function automatic int row_cycles(input op_e op);
		case (op)
			OP_CPU_WRITE: return 530; // 512 DMA cycles plus align, trigger and DMC
			OP_DMC_REQ: return 8;
			default: return 4;
		endcase
	endfunction

	task automatic report_test(input int num, input string name, input int fails_before);
		if (error_count == fails_before) begin
			$display("test %0d %s: passed", num, name);
			tests_passed++;
		end else begin
			$display("test %0d %s: failed with %0d errors", num, name,
				error_count - fails_before);
			tests_failed++;
		end
	endtask

	initial begin
		int fails_before;
		int clocks;
		int total;
		reset = 1'b1;
		dmc_req = 1'b0;
		chr_read = 1'b0;
		chr_write = 1'b0;
		chr_addr = '0;
		chr_din = 8'h00;
		dmc_addr = 16'h0000;
		drive_cpu(1'b1, 16'h4050, 8'h00); // Idle CPU reads open bus, no PRG strobe

		// DMC rows take their address from $random
		set_row(0, OP_CPU_WRITE, 16'h4014, 8'h03, 256, 0, "sprite dma page 03");
		set_row(1, OP_DMC_REQ, 16'h0000, 8'h00, 1, 0, "dmc fetch");
		set_row(2, OP_CPU_WRITE, 16'h4014, 8'h45, 256, 40, "sprite dma with dmc fetch");
		set_row(3, OP_CHR_READ, 16'h8123, 8'h00, model_data(16'h8123), 0,
			"prg read behind chr read");
		set_row(4, OP_CPU_READ, 16'h0155, 8'h00, model_data(16'h0155), 0, "prg read");
		set_row(5, OP_CPU_READ, 16'h4050, 8'h00, model_data(16'h0155), 0, "open bus read");

		total = 20; // Reset and divider checks
		for (int i = 0; i < 6; i++)
			total += row_cycles(tab_op[i]);
		cycle_limit = 2 * 12 * total;

		repeat (10) @(posedge clk);
		#10 reset = 1'b0;

		fails_before = error_count;
		@(negedge clk);
		check_value("pause_cpu after reset", pause_cpu, 0);
		check_value("dmc_ack after reset", dmc_ack, 0);
		check_value("memory_read_cpu after reset", memory_read_cpu, 0);
		check_value("memory_read_ppu after reset", memory_read_ppu, 0);
		check_value("memory_write after reset", memory_write, 0);
		clocks = 1;
		while (!cpu_ce) begin
			@(negedge clk);
			clocks++;
		end
		check_value("clocks to first cpu_ce", clocks, 12);
		check_value("ppu_ce together with cpu_ce", ppu_ce, 1);
		measure_period(1'b1, 12);
		measure_period(1'b0, 4);
		report_test(0, "reset and clock enables", fails_before);

		finish_cpu_cycle(); // Line up with a CPU cycle start
		for (int i = 0; i < 6; i++) begin
			fails_before = error_count;
			ack_count = 0;
			case (tab_op[i])
				OP_CPU_WRITE: sprite_dma(tab_addr[i], tab_data[i], tab_dmc_at[i], tab_exp[i]);
				OP_DMC_REQ: dmc_fetch(tab_exp[i]);
				OP_CHR_READ: chr_then_cpu_read(tab_addr[i], tab_exp[i]);
				default: cpu_read(tab_addr[i], tab_exp[i]);
			endcase
			report_test(i + 1, tab_name[i], fails_before);
		end

		$display("%0d tests, %0d passed, %0d failed, %0d check errors",
			tests_passed + tests_failed, tests_passed, tests_failed, error_count);
		if (error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- verilog/nes_bus_top.sv
// Bus and DMA subsystem
// Clock enables, DMA controller, CPU bus decoder and the shared memory
// arbiter wired together
`timescale 1ns/10ps

module nes_bus_top import nes_bus_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cpu_rnw,
	input logic dmc_req,
	input logic chr_read,
	input logic chr_write,
	input cpu_addr_t cpu_addr,
	input cpu_addr_t dmc_addr,
	input data_t cpu_dout,
	input data_t chr_din,
	input data_t memory_din_cpu,
	input mem_addr_t chr_addr,
	output logic cpu_ce,
	output logic ppu_ce,
	output logic pause_cpu,
	output logic dmc_ack,
	output logic bus_write,
	output logic ppu_write,
	output logic memory_read_cpu,
	output logic memory_read_ppu,
	output logic memory_write,
	output cpu_addr_t bus_addr,
	output data_t bus_dout,
	output data_t cpu_din,
	output data_t memory_dout,
	output mem_addr_t memory_addr
);

	clk_en_if ce_if ();
	dma_bus_if dma_if ();

	logic sprite_trigger;
	logic prg_read;
	logic prg_write;
	mem_addr_t prg_addr;
	data_t prg_din;

	assign cpu_ce = ce_if.cpu_ce;
	assign ppu_ce = ce_if.ppu_ce;

	clock_enables clock_enables_i (
		.clk   (clk),
		.reset (reset),
		.ce    (ce_if.src)
	);

	dma_controller dma_controller_i (
		.clk            (clk),
		.reset          (reset),
		.sprite_trigger (sprite_trigger),
		.cpu_rnw        (cpu_rnw),
		.dmc_req        (dmc_req),
		.cpu_dout       (cpu_dout),
		.cpu_din        (cpu_din),   // Sprite bytes come back on the read path
		.dmc_addr       (dmc_addr),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu),
		.ce             (ce_if.sink),
		.bus            (dma_if.src)
	);

	cpu_bus_decode cpu_bus_decode_i (
		.clk            (clk),
		.reset          (reset),
		.cpu_rnw        (cpu_rnw),
		.cpu_addr       (cpu_addr),
		.cpu_dout       (cpu_dout),
		.memory_din_cpu (memory_din_cpu),
		.ce             (ce_if.sink),
		.dma            (dma_if.sink),
		.bus_addr       (bus_addr),
		.bus_dout       (bus_dout),
		.cpu_din        (cpu_din),
		.bus_write      (bus_write),
		.ppu_write      (ppu_write),
		.sprite_trigger (sprite_trigger),
		.prg_read       (prg_read),
		.prg_write      (prg_write),
		.prg_addr       (prg_addr),
		.prg_din        (prg_din)
	);

	memory_multiplex memory_multiplex_i (
		.clk             (clk),
		.reset           (reset),
		.ce              (ce_if.sink),
		.prg_addr        (prg_addr),
		.prg_read        (prg_read),
		.prg_write       (prg_write),
		.prg_din         (prg_din),
		.chr_addr        (chr_addr),
		.chr_read        (chr_read),
		.chr_write       (chr_write),
		.chr_din         (chr_din),
		.memory_addr     (memory_addr),
		.memory_read_cpu (memory_read_cpu),
		.memory_read_ppu (memory_read_ppu),
		.memory_write    (memory_write),
		.memory_dout     (memory_dout)
	);

endmodule

//--- verilog/memory_multiplex.sv
// Shared memory arbiter
// One external memory serves PPU (CHR) and CPU (PRG) accesses. The PPU
// always wins and is never held off. A CPU request that meets a busy
// PPU is saved and issued at the next idle PPU cycle
`timescale 1ns/10ps

module memory_multiplex import nes_bus_pkg::*; (
	input logic clk,
	input logic reset,
	clk_en_if.sink ce,
	input mem_addr_t prg_addr,
	input logic prg_read,
	input logic prg_write,
	input data_t prg_din,
	input mem_addr_t chr_addr,
	input logic chr_read,
	input logic chr_write,
	input data_t chr_din,
	output mem_addr_t memory_addr,
	output logic memory_read_cpu, // Read into the CPU latch
	output logic memory_read_ppu, // Read into the PPU latch
	output logic memory_write,
	output data_t memory_dout
);

	logic chr_busy;        // PPU owns the memory this cycle
	logic saved_prg_read;  // CPU read waiting for the memory
	logic saved_prg_write; // CPU write, always issued one PPU cycle late

	assign chr_busy = chr_read || chr_write;

	// PPU access goes out in the same cycle
	assign memory_addr = chr_busy ? chr_addr : prg_addr;
	assign memory_read_ppu = chr_read;
	assign memory_read_cpu = !chr_busy && (prg_read || saved_prg_read);
	assign memory_write = chr_busy ? chr_write : saved_prg_write;
	assign memory_dout = chr_write ? chr_din : prg_din;

	always_ff @(posedge clk) begin
		if (reset) begin
			saved_prg_read <= 1'b0;
			saved_prg_write <= 1'b0;
		end else if (ce.ppu_ce) begin
			if (chr_busy) begin
				// Hold CPU requests until the PPU lets go
				saved_prg_read <= prg_read || saved_prg_read;
				saved_prg_write <= prg_write || saved_prg_write;
			end else begin
				saved_prg_read <= 1'b0;        // Read went out this cycle
				saved_prg_write <= prg_write;  // Write data settles first
			end
		end
	end

	// A fresh CPU read only starts inside the PRG window
	a_cpu_read_window: assert property (
		@(posedge clk) disable iff (reset)
		(memory_read_cpu && !saved_prg_read) |-> ce.cart_pre
	) else $error("CPU read started outside the PRG window");

endmodule

//--- verilog/cpu_bus_decode.sv
// CPU bus decoder
// Picks DMA or CPU as bus master, decodes the PPU, open-bus and PRG/RAM
// ranges, and returns read data. Unmapped reads give back the last
// value seen on the bus
`timescale 1ns/10ps

module cpu_bus_decode import nes_bus_pkg::*; (
	input logic clk,
	input logic reset,
	input logic cpu_rnw,
	input cpu_addr_t cpu_addr,
	input data_t cpu_dout,
	input data_t memory_din_cpu, // Data from the shared memory
	clk_en_if.sink ce,
	dma_bus_if.sink dma,
	output cpu_addr_t bus_addr,
	output data_t bus_dout,
	output data_t cpu_din,
	output logic bus_write,
	output logic ppu_write,
	output logic sprite_trigger,
	output logic prg_read,
	output logic prg_write,
	output mem_addr_t prg_addr,
	output data_t prg_din
);

	logic bus_read;
	logic ppu_cs;  // $2000-$3FFF
	logic apu_cs;  // $4000-$4017, nothing fitted
	logic void_cs; // $4018-$40FF
	logic prg_cs;
	data_t open_bus_q;

	// Bus master select
	assign bus_addr = dma.aout_enable ? dma.aout : cpu_addr;
	assign bus_dout = dma.aout_enable ? dma.data_to_ram : cpu_dout;
	assign bus_read = dma.aout_enable ? dma.read : cpu_rnw;
	assign bus_write = !bus_read;

	assign ppu_cs = (bus_addr >= PPU_BASE) && (bus_addr < APU_BASE);
	assign apu_cs = (bus_addr >= APU_BASE) && (bus_addr < OPEN_BASE);
	assign void_cs = (bus_addr >= OPEN_BASE) && (bus_addr < PRG_BASE);
	assign prg_cs = !ppu_cs && !apu_cs && !void_cs; // Low RAM and everything from $4100

	assign ppu_write = bus_write && ppu_cs;
	assign sprite_trigger = bus_write && (bus_addr == SPRITE_DMA_ADDR);

	// PRG strobes only inside the start window
	assign prg_read = bus_read && ce.cart_pre && prg_cs;
	assign prg_write = bus_write && ce.cart_pre && prg_cs;
	assign prg_addr = {{($bits(mem_addr_t) - $bits(cpu_addr_t)){1'b0}}, bus_addr};
	assign prg_din = bus_dout;

	// Only PRG/RAM drives the data bus, everything else floats
	assign cpu_din = prg_cs ? memory_din_cpu : open_bus_q;

	always_ff @(posedge clk) begin
		if (reset)
			open_bus_q <= '0;
		else
			open_bus_q <= cpu_din; // Bus capacitance keeps the last byte
	end

	// DMA writes only ever land on PPU registers
	a_dma_write_ppu: assert property (
		@(posedge clk) disable iff (reset)
		(dma.aout_enable && bus_write) |-> ppu_write
	) else $error("DMA write outside the PPU registers");

endmodule

//--- verilog/dma_controller.sv
// Sprite and DMC DMA controller
// Sprite DMA copies one 256-byte page to OAM as read/write pairs
// (reads on even cycles, writes to $2004 on odd cycles). DMC fetches
// steal an even cycle, and an interrupted sprite transfer resumes on
// the same byte
`timescale 1ns/10ps

module dma_controller import nes_bus_pkg::*; (
	input logic clk,
	input logic reset,
	input logic sprite_trigger, // CPU wrote $4014
	input logic cpu_rnw,        // CPU in a read cycle
	input logic dmc_req,        // Held until dmc_ack
	input data_t cpu_dout,      // Page number on the trigger write
	input data_t cpu_din,       // Read data returned by the bus
	input cpu_addr_t dmc_addr,
	output logic dmc_ack,
	output logic pause_cpu,
	clk_en_if.sink ce,
	dma_bus_if.src bus
);

	spr_state_e spr_state;
	dmc_state_e dmc_state;
	data_t spr_page;  // High byte of the source address
	data_t spr_index; // Byte within the page
	data_t spr_data;  // Byte on its way to OAM
	logic spr_read;   // Sprite read takes this cycle

	// Even cycle in RUN belongs to the sprite read unless DMC took it
	assign spr_read = (spr_state == SPR_RUN) && !ce.odd_cycle && !dmc_ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= DMC_IDLE;
			spr_state <= SPR_IDLE;
			spr_index <= '0;
		end else if (ce.cpu_ce) begin
			// DMC request only taken on an even read cycle
			case (dmc_state)
				DMC_IDLE: if (dmc_req && cpu_rnw && !ce.odd_cycle) dmc_state <= DMC_FETCH;
				DMC_FETCH: if (!ce.odd_cycle) dmc_state <= DMC_IDLE; // Ack cycle done
				default: dmc_state <= DMC_IDLE;
			endcase

			if (sprite_trigger) begin
				spr_state <= SPR_ALIGN;
				spr_index <= '0;
			end else begin
				case (spr_state)
					SPR_ALIGN: if (cpu_rnw && ce.odd_cycle) spr_state <= SPR_RUN;
					SPR_RUN: begin
						if (dmc_ack)
							spr_state <= SPR_ALIGN; // Lose this pair, next odd cycle idles
						else if (ce.odd_cycle) begin
							spr_index <= spr_index + 8'd1;
							if (spr_index == 8'hFF)
								spr_state <= SPR_IDLE; // 256th write done
						end
					end
					default: spr_state <= SPR_IDLE;
				endcase
			end
		end
	end

	// Transfer payload
	always_ff @(posedge clk) begin
		if (ce.cpu_ce && sprite_trigger)
			spr_page <= cpu_dout;
		if (ce.cpu_ce && spr_read)
			spr_data <= cpu_din; // Byte read this even cycle
	end

	assign dmc_ack = (dmc_state == DMC_FETCH) && !ce.odd_cycle;
	assign pause_cpu = ((spr_state != SPR_IDLE) || dmc_req) && cpu_rnw;

	assign bus.aout_enable = dmc_ack || (spr_state == SPR_RUN);
	assign bus.read = !ce.odd_cycle;
	assign bus.data_to_ram = spr_data;
	// DMC first, then page read on even, OAM write on odd
	assign bus.aout = dmc_ack ? dmc_addr :
		!ce.odd_cycle ? {spr_page, spr_index} : OAM_DATA_ADDR;

	// Ack is a pulse of exactly one CPU cycle
	a_ack_one_cycle: assert property (
		@(posedge clk) disable iff (reset)
		(dmc_ack && ce.cpu_ce) |=> !dmc_ack
	) else $error("dmc_ack held past its CPU cycle");

	// Bus ownership only changes at a CPU cycle boundary
	a_bus_owner: assert property (
		@(posedge clk) disable iff (reset)
		(bus.aout_enable && !ce.cpu_ce) |=> bus.aout_enable
	) else $error("DMA let go of the bus inside a CPU cycle");

endmodule

//--- verilog/clock_enables.sv
// Master clock divider
// Produces the CPU (/12) and PPU (/4) clock enables, the PRG access
// window and the even/odd CPU cycle flag
`timescale 1ns/10ps

module clock_enables import nes_timing_pkg::*; (
	input logic clk,
	input logic reset,
	clk_en_if.src ce
);

	div_cnt_t div_cpu; // Runs 1..CPU_DIV
	div_cnt_t div_ppu; // Runs 1..PPU_DIV
	logic odd_q;

	// Both dividers start on 1 together, so every third PPU tick lands on a CPU tick
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu <= DIV_FIRST;
			div_ppu <= DIV_FIRST;
			odd_q <= 1'b0;
		end else begin
			div_cpu <= (div_cpu == CPU_DIV) ? DIV_FIRST : div_cpu + div_cnt_t'(1);
			div_ppu <= (div_ppu == PPU_DIV) ? DIV_FIRST : div_ppu + div_cnt_t'(1);
			if (div_cpu == CPU_DIV)
				odd_q <= ~odd_q; // Flip at the end of each CPU cycle
		end
	end

	assign ce.cpu_ce = (div_cpu == CPU_DIV);
	assign ce.ppu_ce = (div_ppu == PPU_DIV);
	assign ce.odd_cycle = odd_q;

	// Window for starting PRG accesses, first PPU cycle of the CPU cycle
	assign ce.cart_pre = (div_cpu >= DIV_FIRST) && (div_cpu <= CART_PRE_LAST);

	// The two dividers must stay phase locked
	a_cpu_on_ppu: assert property (
		@(posedge clk) disable iff (reset)
		ce.cpu_ce |-> ce.ppu_ce
	) else $error("cpu_ce without ppu_ce");

endmodule

//--- verilog/dma_bus_if.sv
// DMA bus-master request
// When aout_enable is high the DMA controller owns the CPU bus:
// address, direction and write data all come from this bundle
`timescale 1ns/10ps

interface dma_bus_if import nes_bus_pkg::*; ();

	cpu_addr_t aout;     // Address to access
	logic aout_enable;   // DMA wants the bus
	logic read;          // 1 read, 0 write
	data_t data_to_ram;  // Write data

	modport src (output aout, aout_enable, read, data_to_ram);

	modport sink (input aout, aout_enable, read, data_to_ram);

endinterface

//--- verilog/clk_en_if.sv
// Clock enable bundle
// Carries the CPU/PPU enables, the PRG window and the cycle parity
// from the divider to the blocks that run on them
`timescale 1ns/10ps

interface clk_en_if ();

	logic cpu_ce;    // One clk per CPU cycle
	logic ppu_ce;    // One clk per PPU cycle
	logic cart_pre;  // PRG access window
	logic odd_cycle; // Parity of the current CPU cycle

	modport src (output cpu_ce, ppu_ce, cart_pre, odd_cycle);

	modport sink (input cpu_ce, ppu_ce, cart_pre, odd_cycle);

endinterface

//--- verilog/nes_bus_pkg.sv
// CPU bus definitions
// Bus widths, fixed register addresses and the address-range limits used
// by the decoder, plus the DMA state encodings

package nes_bus_pkg;

	typedef logic [15:0] cpu_addr_t; // CPU address
	typedef logic [7:0] data_t;      // Data byte
	typedef logic [21:0] mem_addr_t; // Linear address into the shared memory

	// Sprite DMA page register
	localparam cpu_addr_t SPRITE_DMA_ADDR = 16'h4014;

	// OAM data port, target of every sprite DMA write
	localparam cpu_addr_t OAM_DATA_ADDR = 16'h2004;

	// Address map
	// $0000-$1FFF PRG/RAM
	// $2000-$3FFF PPU registers
	// $4000-$4017 APU and joypads, no device here so open bus
	// $4018-$40FF open bus
	// $4100-$FFFF PRG/RAM again
	localparam cpu_addr_t PPU_BASE = 16'h2000;
	localparam cpu_addr_t APU_BASE = 16'h4000;
	localparam cpu_addr_t OPEN_BASE = 16'h4018;
	localparam cpu_addr_t PRG_BASE = 16'h4100;

	// Sprite DMA FSM
	typedef enum logic [1:0] {
		SPR_IDLE,  // No transfer
		SPR_ALIGN, // Waiting for an odd read cycle
		SPR_RUN    // Read/write pairs in progress
	} spr_state_e;

	// DMC fetch FSM
	typedef enum logic {
		DMC_IDLE,
		DMC_FETCH // Request taken, read on next even cycle
	} dmc_state_e;

endpackage

//--- verilog/nes_timing_pkg.sv
// Master clock timing constants
// NTSC divider ratios and the counter type used by the clock-enable generator
// Both dividers count 1..N and fire on N

package nes_timing_pkg;

	// Divider counter, wide enough for the CPU ratio
	typedef logic [4:0] div_cnt_t;

	// Master clocks per CPU cycle
	localparam div_cnt_t CPU_DIV = 5'd12;

	// Master clocks per PPU cycle
	localparam div_cnt_t PPU_DIV = 5'd4;

	// PRG accesses may only start while the CPU divider is in 1..4
	// This lines the window up with the first PPU cycle of each CPU cycle
	localparam div_cnt_t CART_PRE_LAST = 5'd4;

	// First value of both dividers
	localparam div_cnt_t DIV_FIRST = 5'd1;

endpackage
